// File: bench/char_engine_input.txt
// Columns per frame: cycle_count prg_counter, then reg0 to reg7; frame one, then frame two
// Last block: glyph bitmaps for digits 0 to F, line 7 in the top byte, line 0 in the bottom
1A2B 3C4D
01234567 89ABCDEF FEDCBA98 76543210 DEADBEEF 0BADF00D 55AA33CC F0E1D2C3
E5F6 8097
9ABCDEF0 12345678 0F1E2D3C A7B6C5D4 21524110 F4520FF2 AA55CC33 0F1E2D3C
// Glyphs
3C4242424242423C 7E18181818783818 7E6030180C66663C 7C0606067C06067C
06067E464626160E 780C060C7860607E 3C4242427C40403C 6030180C0606067E
3C4242423C42423C 0606063E4646463C 4242427E4242423C 7C4242467C46427C
3E6060606060603E 7C6262626262627C 3E6060607E60603E 606060607E60607E

// File: char_engine.f
common/char_engine_pkg.sv
verilog/field_counter.sv
render/glyph_rom.sv
render/render_sequencer.sv
render/apb_pixel_writer.sv
verilog/char_engine.sv
bench/tb_clock.sv
bench/char_engine_asserts.sv
bench/char_engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= char_engine_tb
FLIST ?= char_engine.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= TEST PASS
SOURCES := $(wildcard common/*.sv verilog/*.sv render/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/char_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module char_engine_tb;

	wire clock;
	wire arst_n;
	logic [char_engine_pkg::HALF_W-1:0] cycle_count;
	logic [char_engine_pkg::HALF_W-1:0] prg_counter;
	logic [char_engine_pkg::DATA_W-1:0] reg_data;
	logic pready;
	wire char_engine_pkg::reg_index_t reg_sw;
	wire psel;
	wire penable;
	wire pwrite;
	wire char_engine_pkg::addr_t paddr;
	wire [7:0] pwdata;

	logic [63:0] stim [0:35]; // Two frames of ten values, glyphs from entry 20
	logic [7:0] fb [0:65535]; // Frame buffer model
	logic [15:0] lfsr;
	char_engine_pkg::reg_index_t prev_sw;
	int frame_sel;
	int frames_done;
	int frame_xfers;
	int stall_left;
	int cycles;
	int xfers_per_frame;
	int timeout_cycles;
	int byte_errors;
	int sw_errors;
	int bit_errors;
	int count_errors;
	int other_errors;
	int total;

	tb_clock u_clock (
		.clock (clock),
		.arst_n (arst_n)
	);

	char_engine UUT (
		.clock (clock),
		.arst_n (arst_n),
		.cycle_count (cycle_count),
		.prg_counter (prg_counter),
		.reg_data (reg_data),
		.reg_sw (reg_sw),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.pready (pready)
	);

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	function automatic int draw_bits(input int n);
		int bits = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr); // One step per bit
			bits = bits * 2 + int'(lfsr[0]);
		end
		return bits;
	endfunction

	// Is the address inside the cycles, PC or register fields
	function automatic bit in_field(input char_engine_pkg::addr_t a);
		int row = int'(a) / char_engine_pkg::ROW_BYTES;
		int line = (int'(a) % char_engine_pkg::ROW_BYTES) / char_engine_pkg::LINE_BYTES;
		int col = int'(a) % char_engine_pkg::LINE_BYTES;
		if (line >= char_engine_pkg::GLYPH_LINES)
			return 1'b0;
		if (row == 0)
			return col < 4 || (col >= char_engine_pkg::PC_COL && col < char_engine_pkg::PC_COL + 4);
		return row >= char_engine_pkg::REG_ROW0 && row < char_engine_pkg::REG_ROW0 + 8 && col < 8;
	endfunction

	task automatic fill_memory();
		for (int a = 0; a < 65536; a++)
			fb[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A; // Background that follows the address
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errors++;
			$display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_reg_sw(input char_engine_pkg::reg_index_t got,
		input char_engine_pkg::reg_index_t exp);
		if (got !== exp) begin
			sw_errors++;
			$display("Fail %0t reg_sw: got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input char_engine_pkg::addr_t addr,
		input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			byte_errors++;
			$display("Fail %0t %s at %h: got %h expected %h", $time, name, addr, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			count_errors++;
			$display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] value, input int chars,
		input int row, input int col);
		char_engine_pkg::nibble_t nib;
		char_engine_pkg::addr_t a;
		for (int c = 0; c < chars; c++) begin
			nib = value[4 * (chars - 1 - c) +: 4]; // Most significant nibble first
			for (int n = 0; n < char_engine_pkg::GLYPH_LINES; n++) begin
				a = char_engine_pkg::addr_t'(row * char_engine_pkg::ROW_BYTES +
					n * char_engine_pkg::LINE_BYTES + col + c);
				check_byte(name, a, fb[a], stim[20 + int'(nib)][8 * n +: 8]);
			end
		end
	endtask

	task automatic end_frame();
		int base = frame_sel * 10;
		check_count("frame transfers", frame_xfers, xfers_per_frame);
		check_field("cycles", 32'(stim[base][15:0]), 4, 0, char_engine_pkg::CYCLES_COL);
		check_field("pc", 32'(stim[base + 1][15:0]), 4, 0, char_engine_pkg::PC_COL);
		for (int r = 0; r < char_engine_pkg::NUM_REGS; r++)
			check_field($sformatf("reg%0d", r), stim[base + 2 + r][31:0], 8,
				char_engine_pkg::REG_ROW0 + r, char_engine_pkg::REG_COL);
		frame_xfers = 0;
		frames_done++;
		if (frame_sel == 0) begin
			frame_sel = 1; // Second frame shows the changed values
			fill_memory();
		end
	endtask

	// Falling edge work: sweep order, APB slave side, input drive
	task automatic service_cycle();
		int base;
		if (reg_sw !== prev_sw) begin
			check_reg_sw(reg_sw, prev_sw + 3'd1);
			if (prev_sw == 3'd7 && reg_sw == 3'd0)
				end_frame();
			prev_sw = reg_sw;
		end
		if (psel)
			check_bit("pwrite", pwrite, 1'b1); // Every transfer is a write
		if (psel && !penable) begin
			stall_left = draw_bits(2); // 0 to 3 wait states
			pready = 1'b0;
		end else if (psel && penable && stall_left > 0) begin
			stall_left--;
			pready = 1'b0;
		end else begin
			pready = psel && penable;
		end
		if (psel && penable && pready) begin
			if (!in_field(paddr)) begin
				other_errors++;
				$display("Write at %0t went to address %h outside every field", $time, paddr);
			end
			fb[paddr] = pwdata; // Completes at the next rising edge
			frame_xfers++;
		end
		base = frame_sel * 10;
		cycle_count = stim[base][15:0];
		prg_counter = stim[base + 1][15:0];
		reg_data = stim[base + 2 + int'(reg_sw)][31:0];
	endtask

	initial begin
		$readmemh("bench/char_engine_input.txt", stim);
		fill_memory();
		lfsr = 16'd25298;
		prev_sw = '0;
		pready = 1'b0;
		cycle_count = stim[0][15:0];
		prg_counter = stim[1][15:0];
		reg_data = stim[2][31:0];
		xfers_per_frame = (2 * char_engine_pkg::HALF_W / 4 +
			char_engine_pkg::NUM_REGS * char_engine_pkg::DATA_W / 4) * char_engine_pkg::GLYPH_LINES;
		timeout_cycles = 2 * xfers_per_frame * 5 + 500; // Slowest transfer is 5 cycles
		do begin
			@(negedge clock);
			cycles++;
			check_bit("psel", psel, 1'b0);
			check_bit("penable", penable, 1'b0);
			check_reg_sw(reg_sw, '0);
		end while (!arst_n);
		while (frames_done < 2 && cycles < timeout_cycles) begin
			@(negedge clock);
			cycles++;
			service_cycle();
		end
		if (frames_done < 2) begin
			other_errors++;
			$display("Timeout after %0d cycles with %0d of 2 frames finished", cycles, frames_done);
		end
		total = byte_errors + sw_errors + bit_errors + count_errors + other_errors +
			UUT.u_apb_pixel_writer.apb_checks.assert_errors;
		$display("Errors: bytes %0d, reg_sw %0d, signals %0d, counts %0d, other %0d, asserts %0d",
			byte_errors, sw_errors, bit_errors, count_errors, other_errors,
			UUT.u_apb_pixel_writer.apb_checks.assert_errors);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/char_engine_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module char_engine_asserts (
	input wire clock,
	input wire arst_n,
	input wire psel,
	input wire penable,
	input wire char_engine_pkg::addr_t paddr,
	input wire [7:0] pwdata,
	input wire pready
);

	int assert_errors = 0;

	penable_needs_psel: assert property (@(posedge clock) disable iff (!arst_n)
		penable |-> psel)
	else begin
		$error("penable high without psel");
		assert_errors++;
	end

	hold_while_waiting: assert property (@(posedge clock) disable iff (!arst_n)
		psel && penable && !pready |=> $stable(paddr) && $stable(pwdata))
	else begin
		$error("paddr or pwdata moved during a wait state");
		assert_errors++;
	end

	penable_drops: assert property (@(posedge clock) disable iff (!arst_n)
		psel && penable && pready |=> !penable)
	else begin
		$error("penable still high after a completed transfer");
		assert_errors++;
	end

endmodule

bind apb_pixel_writer char_engine_asserts apb_checks (
	.clock (clock),
	.arst_n (arst_n),
	.psel (psel),
	.penable (penable),
	.paddr (paddr),
	.pwdata (pwdata),
	.pready (pready)
);

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arst_n <= 1'b1; // Released away from the active edge
	end

endmodule

`default_nettype wire

// File: verilog/char_engine.sv
`timescale 1ns/100ps
`default_nettype none

module char_engine (
	input wire clock,
	input wire arst_n,
	input wire [char_engine_pkg::HALF_W-1:0] cycle_count,
	input wire [char_engine_pkg::HALF_W-1:0] prg_counter,
	input wire [char_engine_pkg::DATA_W-1:0] reg_data,
	output wire char_engine_pkg::reg_index_t reg_sw,
	output wire psel,
	output wire penable,
	output wire pwrite,
	output wire char_engine_pkg::addr_t paddr,
	output wire [7:0] pwdata,
	input wire pready
);

	wire char_engine_pkg::field_t field;
	wire advance;
	wire char_engine_pkg::nibble_t nibble;
	wire char_engine_pkg::bitmap_t bitmap;
	wire start;
	wire char_engine_pkg::addr_t char_addr;
	wire done;

	field_counter u_field_counter (
		.clock (clock),
		.arst_n (arst_n),
		.advance (advance),
		.field (field),
		.reg_sw (reg_sw) // Also selects reg_data outside
	);

	render_sequencer u_render_sequencer (
		.clock (clock),
		.arst_n (arst_n),
		.field (field),
		.reg_sw (reg_sw),
		.cycle_count (cycle_count),
		.prg_counter (prg_counter),
		.reg_data (reg_data),
		.advance (advance),
		.nibble (nibble),
		.start (start),
		.char_addr (char_addr),
		.done (done)
	);

	glyph_rom u_glyph_rom (
		.clock (clock),
		.nibble (nibble),
		.bitmap (bitmap)
	);

	apb_pixel_writer u_apb_pixel_writer (
		.clock (clock),
		.arst_n (arst_n),
		.start (start),
		.char_addr (char_addr),
		.bitmap (bitmap),
		.done (done),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.pready (pready)
	);

endmodule

`default_nettype wire

// File: render/apb_pixel_writer.sv
`timescale 1ns/100ps
`default_nettype none

module apb_pixel_writer (
	input wire clock,
	input wire arst_n,
	input wire start,
	input wire char_engine_pkg::addr_t char_addr,
	input wire char_engine_pkg::bitmap_t bitmap,
	output logic done,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output char_engine_pkg::addr_t paddr,
	output logic [7:0] pwdata,
	input wire pready
);

	logic [2:0] line; // Scan line of the transfer in flight
	char_engine_pkg::addr_t base;
	char_engine_pkg::bitmap_t glyph;

	always_ff @(posedge clock) begin
		if (start) begin
			base <= char_addr;
			glyph <= bitmap;
		end
	end

	// Setup phase when penable is low, access while both are high
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			psel <= 1'b0;
			penable <= 1'b0;
			line <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				psel <= 1'b1;
				penable <= 1'b0;
				line <= '0;
			end else if (psel && !penable) begin
				penable <= 1'b1;
			end else if (psel && pready) begin
				penable <= 1'b0; // Back to setup for the next line
				if (line == 3'(char_engine_pkg::GLYPH_LINES - 1)) begin
					psel <= 1'b0;
					done <= 1'b1;
				end else begin
					line <= line + 3'd1;
				end
			end
		end
	end

	assign pwrite = psel; // Write only
	assign paddr = base + char_engine_pkg::addr_t'(line) *
		char_engine_pkg::addr_t'(char_engine_pkg::LINE_BYTES);
	assign pwdata = glyph[{line, 3'b000} +: 8]; // Held by line through the wait states

endmodule

`default_nettype wire

// File: render/render_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module render_sequencer (
	input wire clock,
	input wire arst_n,
	input wire char_engine_pkg::field_t field,
	input wire char_engine_pkg::reg_index_t reg_sw,
	input wire [char_engine_pkg::HALF_W-1:0] cycle_count,
	input wire [char_engine_pkg::HALF_W-1:0] prg_counter,
	input wire [char_engine_pkg::DATA_W-1:0] reg_data,
	output logic advance,
	output char_engine_pkg::nibble_t nibble,
	output logic start,
	output char_engine_pkg::addr_t char_addr,
	input wire done
);

	char_engine_pkg::seq_state_t state;
	logic [char_engine_pkg::DATA_W-1:0] value; // Left aligned, top nibble is the next char
	logic [2:0] char_idx; // 0 is the most significant nibble
	logic [3:0] num_chars;
	logic [3:0] row;
	char_engine_pkg::addr_t col;
	logic last_char;

	// Field geometry, stable for the whole field
	always_comb begin
		case (field)
			char_engine_pkg::FLD_CYCLES: begin
				num_chars = 4'(char_engine_pkg::HALF_W / 4);
				row = 4'd0;
				col = char_engine_pkg::addr_t'(char_engine_pkg::CYCLES_COL);
			end
			char_engine_pkg::FLD_PC: begin
				num_chars = 4'(char_engine_pkg::HALF_W / 4);
				row = 4'd0;
				col = char_engine_pkg::addr_t'(char_engine_pkg::PC_COL);
			end
			default: begin
				num_chars = 4'(char_engine_pkg::DATA_W / 4);
				row = 4'(char_engine_pkg::REG_ROW0) + 4'(reg_sw); // One row per register
				col = char_engine_pkg::addr_t'(char_engine_pkg::REG_COL);
			end
		endcase
	end

	assign last_char = ({1'b0, char_idx} == num_chars - 4'd1);
	assign advance = (state == char_engine_pkg::ST_NEXT) && last_char;
	assign nibble = value[char_engine_pkg::DATA_W-1 -: 4];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= char_engine_pkg::ST_SOURCE;
			char_idx <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				char_engine_pkg::ST_SOURCE: begin
					char_idx <= '0;
					state <= char_engine_pkg::ST_DECODE;
				end
				char_engine_pkg::ST_DECODE: begin
					start <= 1'b1; // Bitmap is out of the ROM next cycle
					state <= char_engine_pkg::ST_WRITE;
				end
				char_engine_pkg::ST_WRITE: begin
					if (done)
						state <= char_engine_pkg::ST_NEXT;
				end
				default: begin
					if (last_char) begin
						state <= char_engine_pkg::ST_SOURCE;
					end else begin
						char_idx <= char_idx + 3'd1;
						state <= char_engine_pkg::ST_DECODE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			char_engine_pkg::ST_SOURCE: begin
				case (field)
					char_engine_pkg::FLD_CYCLES: value <= {cycle_count,
						{(char_engine_pkg::DATA_W - char_engine_pkg::HALF_W){1'b0}}};
					char_engine_pkg::FLD_PC: value <= {prg_counter,
						{(char_engine_pkg::DATA_W - char_engine_pkg::HALF_W){1'b0}}};
					default: value <= reg_data; // Selected by reg_sw a cycle earlier
				endcase
			end
			char_engine_pkg::ST_DECODE: begin
				char_addr <= char_engine_pkg::addr_t'(row) *
					char_engine_pkg::addr_t'(char_engine_pkg::ROW_BYTES) +
					col + char_engine_pkg::addr_t'(char_idx);
			end
			char_engine_pkg::ST_NEXT: value <= value << 4; // Bring up the next nibble
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: render/glyph_rom.sv
`timescale 1ns/100ps
`default_nettype none

module glyph_rom (
	input wire clock,
	input wire char_engine_pkg::nibble_t nibble,
	output char_engine_pkg::bitmap_t bitmap
);

	// Byte order is line 7 down to line 0
	always_ff @(posedge clock) begin
		case (nibble)
			4'h0: bitmap <= 64'h3C42_4242_4242_423C;
			4'h1: bitmap <= 64'h7E18_1818_1878_3818;
			4'h2: bitmap <= 64'h7E60_3018_0C66_663C;
			4'h3: bitmap <= 64'h7C06_0606_7C06_067C;
			4'h4: bitmap <= 64'h0606_7E46_4626_160E;
			4'h5: bitmap <= 64'h780C_060C_7860_607E;
			4'h6: bitmap <= 64'h3C42_4242_7C40_403C;
			4'h7: bitmap <= 64'h6030_180C_0606_067E;
			4'h8: bitmap <= 64'h3C42_4242_3C42_423C;
			4'h9: bitmap <= 64'h0606_063E_4646_463C;
			4'hA: bitmap <= 64'h4242_427E_4242_423C;
			4'hB: bitmap <= 64'h7C42_4246_7C46_427C;
			4'hC: bitmap <= 64'h3E60_6060_6060_603E;
			4'hD: bitmap <= 64'h7C62_6262_6262_627C;
			4'hE: bitmap <= 64'h3E60_6060_7E60_603E;
			default: bitmap <= 64'h6060_6060_7E60_607E; // F
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/field_counter.sv
`timescale 1ns/100ps
`default_nettype none

module field_counter (
	input wire clock,
	input wire arst_n,
	input wire advance,
	output char_engine_pkg::field_t field,
	output char_engine_pkg::reg_index_t reg_sw
);

	// Order is cycles, PC, then one field per register
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			field <= char_engine_pkg::FLD_CYCLES;
			reg_sw <= '0;
		end else if (advance) begin
			case (field)
				char_engine_pkg::FLD_CYCLES: field <= char_engine_pkg::FLD_PC;
				char_engine_pkg::FLD_PC: field <= char_engine_pkg::FLD_REG;
				default: begin
					if (reg_sw == char_engine_pkg::reg_index_t'(char_engine_pkg::NUM_REGS - 1)) begin
						field <= char_engine_pkg::FLD_CYCLES; // Frame wraps
						reg_sw <= '0;
					end else begin
						reg_sw <= reg_sw + 3'd1; // Stay in register sweep
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: common/char_engine_pkg.sv
`default_nettype none

package char_engine_pkg;

	localparam int DATA_W = 32; // Register value
	localparam int HALF_W = 16; // Cycle count and PC
	localparam int ADDR_W = 16; // Frame buffer address
	localparam int GLYPH_LINES = 8; // Scan lines per glyph

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [8*GLYPH_LINES-1:0] bitmap_t; // Line 0 in the lowest byte
	typedef logic [3:0] nibble_t;

	localparam int NUM_REGS = 8;
	typedef logic [2:0] reg_index_t;

	// Frame buffer layout, 8x8 glyphs with two spacer lines per text row
	localparam int LINE_BYTES = 80;
	localparam int ROW_BYTES = 800;

	localparam int CYCLES_COL = 0;
	localparam int PC_COL = 10;
	localparam int REG_COL = 0;
	localparam int REG_ROW0 = 1; // Register 0 sits under the top row

	typedef enum logic [1:0] {
		FLD_CYCLES,
		FLD_PC,
		FLD_REG
	} field_t;

	typedef enum logic [1:0] {
		ST_SOURCE, // Capture the field value
		ST_DECODE, // Glyph ROM lookup
		ST_WRITE, // Eight APB writes in flight
		ST_NEXT // Next character or next field
	} seq_state_t;

endpackage

`default_nettype wire
